/* hw/io_host_pkg.sv */
// ----------------------------------------------------------------------
// Shared types for the host controller, 16-bit address and 32-bit words
// Address bits 15:12 pick the region and bits 3:0 pick the register
// ----------------------------------------------------------------------
package io_host_pkg;

    typedef logic [31:0] io_word_t;
    typedef logic [15:0] io_addr_t;

    // Upper address nibble, other values are unmapped
    typedef enum logic [3:0] {
        REGION_REGS = 4'h0,
        REGION_FIFO = 4'h1
    } region_t;

    // Register bus request, 38 bits
    typedef struct packed {
        logic       valid;
        logic       write;
        logic [3:0] index;
        io_word_t   wdata;
    } reg_req_t;

    // Register bus response, 33 bits
    typedef struct packed {
        logic     rvalid;
        io_word_t rdata;
    } reg_rsp_t;

    // Transmit FIFO entry, channel comes from io_addr[7:0]
    typedef struct packed {
        io_word_t   data;
        logic [7:0] channel;
    } tx_entry_t;

    localparam int         REG_COUNT     = 16;
    localparam logic [3:0] GPIO_SNAP_IDX = 4'd15;  // Read-only gpio_in sample
    localparam logic [3:0] GPIO_OUT_IDX  = 4'd14;  // Low half drives gpio_out

endpackage

/* hw/io_fifo.sv */
// ----------------------------------------------------------------------
// Circular FIFO, FIFO_DEPTH a power of two, head shown combinationally
// Push when full and pop when empty are dropped
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module io_fifo #(
    parameter int  FIFO_DEPTH = 32,
    parameter type payload_t  = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    payload_t   mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;  // One extra bit to tell full from empty
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/io_reg_bank.sv */
// ----------------------------------------------------------------------
// 16-word single-port register file, read data one cycle after request
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module io_reg_bank #(
    parameter io_host_pkg::io_word_t REG_INIT = 32'h4B5A6978
) (
    input  logic                  clk,
    input  logic                  rst,
    input  io_host_pkg::reg_req_t bank_req,
    output io_host_pkg::reg_rsp_t bank_rsp,
    input  logic                  snap_write
);

    io_host_pkg::io_word_t regs [io_host_pkg::REG_COUNT];
    io_host_pkg::io_word_t rdata_q;
    logic                  rvalid_q;
    logic                  wr_en;

    // Slot 15 only takes scanner writes
    assign wr_en = bank_req.valid && bank_req.write &&
                   (bank_req.index != io_host_pkg::GPIO_SNAP_IDX || snap_write);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            for (int k = 0; k < io_host_pkg::REG_COUNT; k++) begin
                regs[k] <= REG_INIT + io_host_pkg::io_word_t'(k);
            end
        end else begin
            rvalid_q <= bank_req.valid && !bank_req.write;
            if (wr_en) regs[bank_req.index] <= bank_req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (bank_req.valid && !bank_req.write) rdata_q <= regs[bank_req.index];
    end

    assign bank_rsp.rvalid = rvalid_q;
    assign bank_rsp.rdata  = rdata_q;

endmodule

/* hw/reg_bus_arbiter.sv */
// ----------------------------------------------------------------------
// Fixed-priority register bus arbiter, host always wins
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module reg_bus_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  io_host_pkg::reg_req_t host_req,
    input  io_host_pkg::reg_req_t scan_req,
    output logic                  host_gnt,
    output logic                  scan_gnt,
    output io_host_pkg::reg_req_t bank_req,
    input  io_host_pkg::reg_rsp_t bank_rsp,
    output io_host_pkg::reg_rsp_t host_rsp,
    output io_host_pkg::reg_rsp_t scan_rsp
);

    logic owner_scan;  // Issuer of the read now in the bank

    assign host_gnt = host_req.valid;
    assign scan_gnt = scan_req.valid && !host_req.valid;
    assign bank_req = host_gnt ? host_req : scan_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner_scan <= 1'b0;
        end else if (bank_req.valid && !bank_req.write) begin
            owner_scan <= scan_gnt;
        end
    end

    // Data goes to both, rvalid only to the owner
    assign host_rsp.rvalid = bank_rsp.rvalid && !owner_scan;
    assign host_rsp.rdata  = bank_rsp.rdata;
    assign scan_rsp.rvalid = bank_rsp.rvalid && owner_scan;
    assign scan_rsp.rdata  = bank_rsp.rdata;

endmodule

/* hw/gpio_scanner.sv */
// ----------------------------------------------------------------------
// GPIO scanner, writes gpio_in to slot 15 then reads slot 14 to gpio_out
// A tick that lands while a scan is still running is skipped
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module gpio_scanner #(
    parameter int SCAN_PERIOD = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [15:0]           gpio_in,
    output logic [15:0]           gpio_out,
    output io_host_pkg::reg_req_t scan_req,
    input  logic                  scan_gnt,
    input  io_host_pkg::reg_rsp_t scan_rsp
);

    localparam int CNT_W = $clog2(SCAN_PERIOD + 1);

    typedef enum logic [1:0] {SC_IDLE, SC_WRITE, SC_READ, SC_RESP} scan_state_t;

    scan_state_t      state;
    logic [CNT_W-1:0] cnt;
    logic             tick;

    assign tick = (cnt == CNT_W'(SCAN_PERIOD - 1));

    assign scan_req.valid = (state == SC_WRITE) || (state == SC_READ);
    assign scan_req.write = (state == SC_WRITE);
    assign scan_req.index = (state == SC_WRITE) ? io_host_pkg::GPIO_SNAP_IDX
                                                : io_host_pkg::GPIO_OUT_IDX;
    assign scan_req.wdata = {16'h0, gpio_in};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= SC_IDLE;
            cnt      <= '0;
            gpio_out <= '0;
        end else begin
            cnt <= tick ? '0 : cnt + 1'b1;  // Free-running period
            case (state)
                SC_IDLE:  if (tick) state <= SC_WRITE;
                SC_WRITE: if (scan_gnt) state <= SC_READ;
                SC_READ:  if (scan_gnt) state <= SC_RESP;
                SC_RESP: begin
                    if (scan_rsp.rvalid) begin
                        gpio_out <= scan_rsp.rdata[15:0];
                        state    <= SC_IDLE;
                    end
                end
                default: state <= SC_IDLE;
            endcase
        end
    end

endmodule

/* hw/io_host_port.sv */
// ----------------------------------------------------------------------
// Host access FSM, one access in flight, strobes while busy are dropped
// Fixed latency relies on the host always winning the register bus
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module io_host_port (
    input  logic                   clk,
    input  logic                   rst,
    input  io_host_pkg::io_addr_t  io_addr,
    input  io_host_pkg::io_word_t  io_wdata,
    input  logic                   io_read,
    input  logic                   io_write,
    output io_host_pkg::io_word_t  io_rdata,
    output logic                   io_ready,
    output io_host_pkg::reg_req_t  reg_req,
    input  logic                   reg_gnt,
    input  io_host_pkg::reg_rsp_t  reg_rsp,
    output logic                   tx_push,
    output io_host_pkg::tx_entry_t tx_push_entry,
    output logic                   rx_pop,
    input  io_host_pkg::io_word_t  rx_head,
    input  logic                   rx_empty
);

    typedef enum logic [1:0] {S_IDLE, S_DECODE, S_ACCESS, S_RESPOND} state_t;

    state_t                state;
    logic                  op_write;  // Latched at the strobe
    io_host_pkg::io_addr_t addr_q;
    io_host_pkg::io_word_t wdata_q;
    io_host_pkg::region_t  region_q;
    logic                  in_regs;
    logic                  in_fifo;

    assign in_regs = (state == S_ACCESS) && (region_q == io_host_pkg::REGION_REGS);
    assign in_fifo = (state == S_ACCESS) && (region_q == io_host_pkg::REGION_FIFO);

    assign reg_req.valid = in_regs;
    assign reg_req.write = op_write;
    assign reg_req.index = addr_q[3:0];
    assign reg_req.wdata = wdata_q;

    // FIFO strobes last exactly the access cycle
    assign tx_push               = in_fifo && op_write;
    assign tx_push_entry.data    = wdata_q;
    assign tx_push_entry.channel = addr_q[7:0];
    assign rx_pop                = in_fifo && !op_write && !rx_empty;

    always_ff @(posedge clk) begin
        if (state == S_IDLE && (io_read || io_write)) begin
            addr_q  <= io_addr;
            wdata_q <= io_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            op_write <= 1'b0;
            region_q <= io_host_pkg::REGION_REGS;
            io_rdata <= '0;
            io_ready <= 1'b0;
        end else begin
            io_ready <= 1'b0;  // One-cycle pulse
            case (state)
                S_IDLE: begin
                    if (io_read || io_write) begin
                        op_write <= io_write;
                        state    <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    region_q <= io_host_pkg::region_t'(addr_q[15:12]);
                    state    <= S_ACCESS;
                end
                S_ACCESS: begin
                    io_rdata <= '0;  // Writes, empty pops and unmapped reads give zero
                    if (in_fifo && !op_write && !rx_empty) begin
                        io_rdata <= rx_head;  // Head before the pop lands
                    end
                    // Hold the request until granted
                    if (!in_regs || reg_gnt) begin
                        state <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    if (reg_rsp.rvalid) begin
                        io_rdata <= reg_rsp.rdata;
                    end
                    io_ready <= 1'b1;
                    state    <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* hw/io_host_top.sv */
// ----------------------------------------------------------------------
// Host controller top, strobe to io_ready takes a fixed 3 cycles
// FIFO_DEPTH must be a power of two
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module io_host_top #(
    parameter int                    FIFO_DEPTH  = 32,
    parameter io_host_pkg::io_word_t REG_INIT    = 32'h4B5A6978,
    parameter int                    SCAN_PERIOD = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  io_host_pkg::io_addr_t  io_addr,
    input  io_host_pkg::io_word_t  io_wdata,
    input  logic                   io_read,
    input  logic                   io_write,
    output io_host_pkg::io_word_t  io_rdata,
    output logic                   io_ready,
    input  logic [15:0]            gpio_in,
    output logic [15:0]            gpio_out,
    input  logic                   tx_pop,
    output io_host_pkg::tx_entry_t tx_entry,
    output logic                   tx_avail,
    input  logic                   rx_push,
    input  io_host_pkg::io_word_t  rx_data,
    output logic                   rx_space
);

    io_host_pkg::reg_req_t  host_req;
    io_host_pkg::reg_req_t  scan_req;
    io_host_pkg::reg_req_t  bank_req;
    io_host_pkg::reg_rsp_t  host_rsp;
    io_host_pkg::reg_rsp_t  scan_rsp;
    io_host_pkg::reg_rsp_t  bank_rsp;
    logic                   host_gnt;
    logic                   scan_gnt;
    logic                   tx_push;
    io_host_pkg::tx_entry_t tx_push_entry;
    logic                   tx_empty;
    logic                   rx_pop;
    io_host_pkg::io_word_t  rx_head;
    logic                   rx_empty;
    logic                   rx_full;

    assign tx_avail = !tx_empty;
    assign rx_space = !rx_full;

    io_host_port u_port (
        .clk, .rst, .io_addr, .io_wdata, .io_read, .io_write, .io_rdata, .io_ready,
        .reg_req(host_req), .reg_gnt(host_gnt), .reg_rsp(host_rsp),
        .tx_push, .tx_push_entry, .rx_pop, .rx_head, .rx_empty
    );

    gpio_scanner #(.SCAN_PERIOD(SCAN_PERIOD)) u_scanner (
        .clk, .rst, .gpio_in, .gpio_out,
        .scan_req, .scan_gnt, .scan_rsp
    );

    reg_bus_arbiter u_arbiter (
        .clk, .rst, .host_req, .scan_req, .host_gnt, .scan_gnt,
        .bank_req, .bank_rsp, .host_rsp, .scan_rsp
    );

    // Snapshot slot only writable while the scanner owns the bus
    io_reg_bank #(.REG_INIT(REG_INIT)) u_bank (
        .clk, .rst, .bank_req, .bank_rsp, .snap_write(scan_gnt)
    );

    io_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(io_host_pkg::tx_entry_t)) tx_fifo (
        .clk, .rst, .push(tx_push), .push_data(tx_push_entry), .pop(tx_pop),
        .head(tx_entry), .empty(tx_empty), .full()
    );

    io_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(io_host_pkg::io_word_t)) rx_fifo (
        .clk, .rst, .push(rx_push), .push_data(rx_data), .pop(rx_pop),
        .head(rx_head), .empty(rx_empty), .full(rx_full)
    );

endmodule

/* include/io_host_tb_tasks.svh */
// ----------------------------------------------------------------------
// Testbench compare and host bus tasks, included inside io_host_tb
// Drives stimulus on the falling edge of clk
// ----------------------------------------------------------------------
`ifndef IO_HOST_TB_TASKS_SVH
`define IO_HOST_TB_TASKS_SVH

task automatic fail_now(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
endtask

task automatic check_word(input io_host_pkg::io_word_t got, input io_host_pkg::io_word_t exp,
                          input string msg);
    if (got !== exp) fail_now($sformatf("%s got %h expected %h", msg, got, exp));
endtask

task automatic check_tx(input io_host_pkg::tx_entry_t got, input io_host_pkg::tx_entry_t exp,
                        input string msg);
    if (got !== exp) fail_now($sformatf("%s got %h expected %h", msg, got, exp));
endtask

task automatic check_gpio(input logic [15:0] got, input logic [15:0] exp, input string msg);
    if (got !== exp) fail_now($sformatf("%s got %h expected %h", msg, got, exp));
endtask

// One host access, returns read data and cycles from strobe to io_ready
task automatic host_access(input logic wr, input io_host_pkg::io_addr_t addr,
                           input io_host_pkg::io_word_t data,
                           output io_host_pkg::io_word_t rdata, output int cycles);
    @(negedge clk);
    io_addr  = addr;
    io_wdata = data;
    io_write = wr;
    io_read  = !wr;
    @(negedge clk);
    io_write = 1'b0;
    io_read  = 1'b0;
    cycles   = 1;
    while (!io_ready) begin
        if (cycles > 4) fail_now("host access never raised io_ready within 4 cycles");
        @(negedge clk);
        cycles++;
    end
    rdata = io_rdata;
endtask

`endif

/* dv/io_host_tb.sv */
// ----------------------------------------------------------------------
// Directed testbench for io_host_top, run with FIFO_DEPTH of 8
// Inputs change on the falling edge, outputs sampled on the falling edge
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module io_host_tb;

    localparam int                    CLK_PERIOD  = 100;
    localparam int                    FIFO_DEPTH  = 8;
    localparam io_host_pkg::io_word_t REG_INIT    = 32'h4B5A6978;
    localparam int                    SCAN_PERIOD = 8;
    localparam int                    READY_EDGES = 4;  // Strobe edge plus 3 cycles
    localparam int                    NUM_TESTS   = 6;
    // Longest test is the register write test, 30 host accesses
    localparam int                    MAX_TEST_CYCLES = 32 * (READY_EDGES + 1);

    logic                   clk = 1'b0;
    logic                   rst;
    io_host_pkg::io_addr_t  io_addr;
    io_host_pkg::io_word_t  io_wdata;
    logic                   io_read;
    logic                   io_write;
    io_host_pkg::io_word_t  io_rdata;
    logic                   io_ready;
    logic [15:0]            gpio_in;
    logic [15:0]            gpio_out;
    logic                   tx_pop;
    io_host_pkg::tx_entry_t tx_entry;
    logic                   tx_avail;
    logic                   rx_push;
    io_host_pkg::io_word_t  rx_data;
    logic                   rx_space;

    int                     seed = 355;
    io_host_pkg::io_word_t  reg_model [16];  // Expected bank contents

    io_host_top #(
        .FIFO_DEPTH(FIFO_DEPTH), .REG_INIT(REG_INIT), .SCAN_PERIOD(SCAN_PERIOD)
    ) uut (
        .clk, .rst, .io_addr, .io_wdata, .io_read, .io_write, .io_rdata, .io_ready,
        .gpio_in, .gpio_out, .tx_pop, .tx_entry, .tx_avail,
        .rx_push, .rx_data, .rx_space
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

`include "io_host_tb_tasks.svh"

    task automatic stop_with_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_latency(input int cycles, input string msg);
        if (cycles != READY_EDGES) begin
            stop_with_error($sformatf("%s: io_ready after %0d falling edges, not %0d",
                                      msg, cycles, READY_EDGES));
        end
    endtask

    task automatic read_check(input io_host_pkg::io_addr_t addr,
                              input io_host_pkg::io_word_t exp, input string msg);
        io_host_pkg::io_word_t rd;
        int                    cyc;
        host_access(1'b0, addr, '0, rd, cyc);
        check_latency(cyc, msg);
        check_word(rd, exp, msg);
    endtask

    task automatic write_only(input io_host_pkg::io_addr_t addr,
                              input io_host_pkg::io_word_t data, input string msg);
        io_host_pkg::io_word_t rd;
        int                    cyc;
        host_access(1'b1, addr, data, rd, cyc);
        check_latency(cyc, msg);
    endtask

    // Expected value of any slot, slot 15 mirrors gpio_in
    function automatic io_host_pkg::io_word_t slot_value(input int k);
        if (k == 15) return {16'h0, gpio_in};
        return reg_model[k];
    endfunction

    task automatic reset_value_reads();
        io_host_pkg::io_word_t init14;
        for (int k = 0; k < 16; k++) begin
            reg_model[k] = REG_INIT + io_host_pkg::io_word_t'(k);
        end
        for (int k = 0; k < 16; k++) begin
            read_check(io_host_pkg::io_addr_t'(k), slot_value(k),
                       $sformatf("reset reg %0d", k));
        end
        init14 = REG_INIT + 32'd14;
        check_gpio(gpio_out, init14[15:0], "gpio_out from reset slot 14");
    endtask

    task automatic reg_write_readback();
        io_host_pkg::io_word_t data;
        for (int k = 0; k < 14; k++) begin
            data = $random(seed);
            write_only(io_host_pkg::io_addr_t'(k), data, $sformatf("write reg %0d", k));
            reg_model[k] = data;
            read_check(io_host_pkg::io_addr_t'(k), data, $sformatf("readback reg %0d", k));
        end
        data = $random(seed);
        write_only(16'h000F, data, "host write to snapshot");  // Must be dropped
        read_check(16'h000F, slot_value(15), "snapshot after host write");
    endtask

    task automatic gpio_round_trip();
        io_host_pkg::io_word_t rnd;
        io_host_pkg::io_word_t w;
        int                    waited;
        rnd = $random(seed);
        @(negedge clk);
        gpio_in = rnd[15:0];
        repeat (3 * SCAN_PERIOD) @(negedge clk);
        read_check(16'h000F, {16'h0, rnd[15:0]}, "gpio snapshot");
        w = $random(seed);
        write_only(16'h000E, w, "write gpio_out reg");
        reg_model[14] = w;
        waited = 0;
        while (gpio_out !== w[15:0] && waited < 3 * SCAN_PERIOD) begin
            @(negedge clk);
            waited++;
        end
        check_gpio(gpio_out, w[15:0], "gpio_out after slot 14 write");
    endtask

    task automatic tx_fifo_drain();
        io_host_pkg::tx_entry_t exp_q[$];
        io_host_pkg::tx_entry_t ent;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            ent.data    = $random(seed);
            ent.channel = 8'(i * 7 + 3);
            write_only({4'h1, 4'h0, ent.channel}, ent.data, $sformatf("tx push %0d", i));
            if (i < FIFO_DEPTH) exp_q.push_back(ent);  // Extra writes are dropped
        end
        while (exp_q.size() > 0) begin
            ent = exp_q.pop_front();
            if (!tx_avail) stop_with_error("tx_avail low while entries are still expected");
            check_tx(tx_entry, ent, "tx head");
            tx_pop = 1'b1;
            @(negedge clk);
            tx_pop = 1'b0;
        end
        if (tx_avail) stop_with_error("tx FIFO still holds entries beyond its depth");
    endtask

    task automatic rx_fifo_reads();
        io_host_pkg::io_word_t exp_q[$];
        io_host_pkg::io_word_t data;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            if (!rx_space) stop_with_error("rx_space low on a nearly empty FIFO");
            data    = $random(seed);
            rx_data = data;
            rx_push = 1'b1;
            exp_q.push_back(data);
        end
        @(negedge clk);
        rx_push = 1'b0;
        while (exp_q.size() > 0) begin
            data = exp_q.pop_front();
            read_check(16'h1000, data, "rx pop");
        end
        read_check(16'h1000, '0, "rx pop when empty");
        read_check(16'h2000, '0, "unmapped region read");
    endtask

    // Random mix of register accesses while the scanner keeps polling
    task automatic back_to_back_regs();
        io_host_pkg::io_word_t rnd;
        io_host_pkg::io_word_t data;
        int                    idx;
        for (int i = 0; i < 24; i++) begin
            rnd  = $random(seed);
            data = $random(seed);
            idx  = int'(rnd[3:0]);
            if (rnd[4]) begin
                write_only(io_host_pkg::io_addr_t'(idx), data, $sformatf("b2b write %0d", i));
                if (idx != 15) reg_model[idx] = data;
            end else begin
                read_check(io_host_pkg::io_addr_t'(idx), slot_value(idx),
                           $sformatf("b2b read %0d", i));
            end
        end
    endtask

    initial begin
        #(CLK_PERIOD * (NUM_TESTS * MAX_TEST_CYCLES + 100));
        $display("ERROR: watchdog expired, the tests did not finish in time");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    initial begin
        rst      = 1'b1;
        io_addr  = '0;
        io_wdata = '0;
        io_read  = 1'b0;
        io_write = 1'b0;
        gpio_in  = '0;
        tx_pop   = 1'b0;
        rx_push  = 1'b0;
        rx_data  = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        reset_value_reads();
        reg_write_readback();
        gpio_round_trip();
        tx_fifo_drain();
        rx_fifo_reads();
        back_to_back_regs();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
hw/io_host_pkg.sv
hw/io_fifo.sv
hw/io_reg_bank.sv
hw/reg_bus_arbiter.sv
hw/gpio_scanner.sv
hw/io_host_port.sv
hw/io_host_top.sv
dv/io_host_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the io_host_top testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
FAIL_MSG="Simulation finished: FAIL"

verilator --binary --timing -f list.f --top-module io_host_tb -Mdir "$OBJ" -j 0
if [ $? -ne 0 ]; then
    echo "ERROR: Verilator build failed"
    exit 1
fi

"./$OBJ/Vio_host_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "ERROR: testbench reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "ERROR: simulation exited with status $run_status"
    exit 1
fi

echo "Simulation run complete"
exit 0
